/* Bender.yml */
package:
  name: keyboard_synth

sources:
  # design, package first
  - src/synth_pkg.sv
  - src/key_control.sv
  - src/tone_osc.sv
  - src/adsr_env.sv
  - src/voice_mix.sv
  - src/synth_top.sv

  # testbench
  - target: test
    files:
      - testbench/synth_checker.sv
      - testbench/synth_tb.sv

/* src.f */
src/synth_pkg.sv
src/key_control.sv
src/tone_osc.sv
src/adsr_env.sv
src/voice_mix.sv
src/synth_top.sv
testbench/synth_checker.sv
testbench/synth_tb.sv

/* src/adsr_env.sv */
`timescale 1ns/1ps

module adsr_env
    import synth_pkg::*;
#(
    parameter int ENV_DIV = 16
) (
    input  logic   clk,
    input  logic   reset,
    input  logic   gate,
    input  param_t attack,
    input  param_t decay,
    input  param_t sustain,
    input  param_t rel,
    output param_t env_level
);

    localparam int CNT_W = (ENV_DIV > 1) ? $clog2(ENV_DIV) : 1;

    // envelope phases
    localparam logic [2:0] PH_IDLE    = 3'd0;
    localparam logic [2:0] PH_ATTACK  = 3'd1;
    localparam logic [2:0] PH_DECAY   = 3'd2;
    localparam logic [2:0] PH_SUSTAIN = 3'd3;
    localparam logic [2:0] PH_RELEASE = 3'd4;

    logic [CNT_W-1:0] tick_cnt;
    logic             tick;       // one cycle in ENV_DIV
    logic             gate_q;
    logic [2:0]       phase;
    logic [2:0]       phase_nxt;
    param_t           level_nxt;
    logic [6:0]       att_sum;    // extra bit catches overflow
    logic [6:0]       dec_diff;   // msb set means below 0
    logic [6:0]       rel_diff;

    // free-running divider
    assign tick = (tick_cnt == CNT_W'(ENV_DIV - 1));

    always_ff @(posedge clk) begin
        if (!reset)
            tick_cnt <= '0;
        else if (tick)
            tick_cnt <= '0;
        else
            tick_cnt <= tick_cnt + 1'b1;
    end

    assign att_sum  = {1'b0, env_level} + {1'b0, attack} + 7'd1;
    assign dec_diff = {1'b0, env_level} - {1'b0, decay};
    assign rel_diff = {1'b0, env_level} - {1'b0, rel} - 7'd1;

    always_comb begin
        phase_nxt = phase;
        level_nxt = env_level;
        if (gate && !gate_q) begin
            phase_nxt = PH_ATTACK;               // new press, from wherever
        end else if (!gate && gate_q) begin
            phase_nxt = PH_RELEASE;
        end else if (phase == PH_SUSTAIN && env_level > sustain) begin
            phase_nxt = PH_DECAY;                // sustain stepped below level
        end else if (tick) begin
            case (phase)
                PH_ATTACK: begin
                    if (att_sum >= 7'(PARAM_MAX)) begin
                        level_nxt = PARAM_MAX;   // cap and go on to decay
                        phase_nxt = PH_DECAY;
                    end else begin
                        level_nxt = att_sum[5:0];
                    end
                end
                PH_DECAY: begin
                    if (env_level <= sustain) begin
                        phase_nxt = PH_SUSTAIN;  // already there
                    end else if (dec_diff[6] || dec_diff[5:0] <= sustain) begin
                        level_nxt = sustain;
                        phase_nxt = PH_SUSTAIN;
                    end else begin
                        level_nxt = dec_diff[5:0];
                    end
                end
                PH_RELEASE: begin
                    if (rel_diff[6] || rel_diff == 7'd0) begin
                        level_nxt = '0;
                        phase_nxt = PH_IDLE;
                    end else begin
                        level_nxt = rel_diff[5:0];
                    end
                end
                default: ;                       // idle and sustain hold
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            gate_q    <= 1'b0;
            phase     <= PH_IDLE;
            env_level <= '0;
        end else begin
            gate_q    <= gate;
            phase     <= phase_nxt;
            env_level <= level_nxt;
        end
    end

    // a change of sustain from key_control gets one cycle to pull us back to decay
    level_within_sustain: assert property (
        @(posedge clk) disable iff (!reset)
        (phase == PH_SUSTAIN && $stable(sustain)) |-> (env_level <= sustain)
    );

endmodule

/* src/key_control.sv */
`timescale 1ns/1ps

module key_control
    import synth_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       key_valid,    // one-cycle strobe
    input  key_event_t key_code,
    output logic [3:0] note,
    output logic       gate,
    output logic [2:0] octave,
    output param_t     amplitude,
    output param_t     attack,
    output param_t     decay,
    output param_t     sustain,
    output param_t     rel,
    output stage_e     stage_sel,
    output param_t     stage_value
);

    logic press_ok;    // valid press of a real note
    logic release_ok;  // release of the note being held
    logic adjust_ok;   // slider step or select

    // one step toward up/down, stuck at 0 and PARAM_MAX
    function automatic param_t step_param(input param_t value, input logic up);
        param_t result;
        result = value;
        if (up && value != PARAM_MAX)
            result = value + 1'b1;
        else if (!up && value != '0)
            result = value - 1'b1;
        return result;
    endfunction

    // same for the 3-bit octave
    function automatic logic [2:0] step_octave(input logic [2:0] value, input logic up);
        logic [2:0] result;
        result = value;
        if (up && value != OCTAVE_MAX)
            result = value + 1'b1;
        else if (!up && value != '0)
            result = value - 1'b1;
        return result;
    endfunction

    // note view
    assign press_ok   = key_valid && !key_code.nt.kind && key_code.nt.press
                        && (key_code.nt.index <= 4'd11);
    assign release_ok = key_valid && !key_code.nt.kind && !key_code.nt.press
                        && (key_code.nt.index == note); // other notes leave gate alone
    // adjust view
    assign adjust_ok  = key_valid && key_code.adj.kind;

    always_ff @(posedge clk) begin
        if (!reset) begin
            note      <= '0;
            gate      <= 1'b0;
            octave    <= DEF_OCTAVE;
            amplitude <= DEF_AMPLITUDE;
            attack    <= DEF_ATTACK;
            decay     <= DEF_DECAY;
            sustain   <= DEF_SUSTAIN;
            rel       <= DEF_RELEASE;
            stage_sel <= STAGE_ATTACK;
        end else begin
            if (press_ok) begin
                note <= key_code.nt.index;
                gate <= 1'b1;
            end else if (release_ok) begin
                gate <= 1'b0;
            end

            if (adjust_ok) begin
                case (key_code.adj.target)
                    2'd0: octave    <= step_octave(octave, key_code.adj.up);
                    2'd1: amplitude <= step_param(amplitude, key_code.adj.up);
                    2'd2: stage_sel <= stage_e'(key_code.adj.stage); // pick stage
                    default: begin // step the selected stage only
                        case (stage_sel)
                            STAGE_ATTACK:  attack  <= step_param(attack, key_code.adj.up);
                            STAGE_DECAY:   decay   <= step_param(decay, key_code.adj.up);
                            STAGE_SUSTAIN: sustain <= step_param(sustain, key_code.adj.up);
                            default:       rel     <= step_param(rel, key_code.adj.up);
                        endcase
                    end
                endcase
            end
        end
    end

    // value shown for the stage under edit
    always_comb begin
        case (stage_sel)
            STAGE_ATTACK:  stage_value = attack;
            STAGE_DECAY:   stage_value = decay;
            STAGE_SUSTAIN: stage_value = sustain;
            default:       stage_value = rel;
        endcase
    end

endmodule

/* src/synth_pkg.sv */
package synth_pkg;

    // 6-bit slider word for amplitude, stage values and envelope level
    typedef logic [5:0] param_t;

    // one key word from the keyboard front end
    // kind picks the view: 0 note, 1 adjust
    typedef union packed {
        struct packed {
            logic       kind;   // 0 here
            logic       press;  // 1 press, 0 release
            logic [1:0] spare;
            logic [3:0] index;  // 0..11 is C..B, 12..15 unused
        } nt;
        struct packed {
            logic       kind;   // 1 here
            logic [1:0] target; // 0 octave, 1 amplitude, 2 select stage, 3 stage value
            logic [1:0] stage;  // only read by select
            logic [1:0] spare;
            logic       up;     // 1 up, 0 down
        } adj;
    } key_event_t;

    // which envelope stage the value slider acts on
    typedef enum logic [1:0] {
        STAGE_ATTACK  = 2'd0,
        STAGE_DECAY   = 2'd1,
        STAGE_SUSTAIN = 2'd2,
        STAGE_RELEASE = 2'd3
    } stage_e;

    // slider limits
    localparam param_t     PARAM_MAX  = 6'd63;
    localparam logic [2:0] OCTAVE_MAX = 3'd7;

    // power-up slider values
    localparam logic [2:0] DEF_OCTAVE    = 3'd4;  // middle octave
    localparam param_t     DEF_AMPLITUDE = 6'd63; // full volume
    localparam param_t     DEF_ATTACK    = 6'd63; // instant attack
    localparam param_t     DEF_DECAY     = 6'd0;  // no decay
    localparam param_t     DEF_SUSTAIN   = 6'd63; // hold at full level
    localparam param_t     DEF_RELEASE   = 6'd63; // instant release

    // phase increments for octave 0, equal-tempered ratios off C = 256
    // octave shifts these left, so 483 << 7 still fits a 20-bit phase
    localparam logic [15:0] NOTE_INC [12] = '{
        16'd256, 16'd271, 16'd287, 16'd304, // C  C# D  D#
        16'd323, 16'd342, 16'd362, 16'd384, // E  F  F# G
        16'd406, 16'd431, 16'd456, 16'd483  // G# A  A# B
    };

endpackage

/* src/synth_top.sv */
`timescale 1ns/1ps

module synth_top
    import synth_pkg::*;
#(
    parameter int ENV_DIV = 16,  // cycles per envelope tick
    parameter int PHASE_W = 20   // oscillator phase width
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       key_valid,
    input  key_event_t key_code,
    output logic [6:0] wave_out,
    output param_t     env_level,
    output logic       gate,
    output logic [2:0] octave,
    output param_t     amplitude,
    output stage_e     stage_sel,
    output param_t     stage_value
);

    logic [3:0] note;
    param_t     attack;
    param_t     decay;
    param_t     sustain;
    param_t     rel;
    logic [6:0] saw;

    // key words in, slider registers out
    key_control u_key_control (
        .clk         (clk),
        .reset       (reset),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .note        (note),
        .gate        (gate),
        .octave      (octave),
        .amplitude   (amplitude),
        .attack      (attack),
        .decay       (decay),
        .sustain     (sustain),
        .rel         (rel),
        .stage_sel   (stage_sel),
        .stage_value (stage_value)
    );

    // pitch side
    tone_osc #(
        .PHASE_W (PHASE_W)
    ) u_tone_osc (
        .clk    (clk),
        .reset  (reset),
        .note   (note),
        .octave (octave),
        .gate   (gate),
        .saw    (saw)
    );

    // level side
    adsr_env #(
        .ENV_DIV (ENV_DIV)
    ) u_adsr_env (
        .clk       (clk),
        .reset     (reset),
        .gate      (gate),
        .attack    (attack),
        .decay     (decay),
        .sustain   (sustain),
        .rel       (rel),
        .env_level (env_level)
    );

    voice_mix u_voice_mix (
        .clk       (clk),
        .reset     (reset),
        .saw       (saw),
        .env_level (env_level),
        .amplitude (amplitude),
        .wave_out  (wave_out)
    );

endmodule

/* src/tone_osc.sv */
`timescale 1ns/1ps

module tone_osc
    import synth_pkg::*;
#(
    parameter int PHASE_W = 20
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [3:0] note,
    input  logic [2:0] octave,
    input  logic       gate,
    output logic [6:0] saw
);

    logic [PHASE_W-1:0] phase_acc;  // sawtooth phase
    logic [PHASE_W-1:0] inc;        // per-cycle step for note and octave
    logic [15:0]        base_inc;   // octave 0 step
    logic               gate_q;     // for rise detect

    // 12..15 never held by key_control, treat as silent
    always_comb begin
        if (note <= 4'd11)
            base_inc = NOTE_INC[note];
        else
            base_inc = '0;
    end

    // each octave doubles the step
    assign inc = PHASE_W'(base_inc) << octave;

    always_ff @(posedge clk) begin
        if (!reset) begin
            gate_q    <= 1'b0;
            phase_acc <= '0;
        end else begin
            gate_q <= gate;
            if (gate && !gate_q)
                phase_acc <= '0;              // restart on each new press
            else if (gate)
                phase_acc <= phase_acc + inc; // wraps naturally
            // gate low: hold phase
        end
    end

    // top bits of phase form the ramp
    assign saw = phase_acc[PHASE_W-1 -: 7];

    // any held note must have a real pitch
    inc_nonzero_when_gated: assert property (
        @(posedge clk) disable iff (!reset)
        gate |-> (inc != '0)
    );

endmodule

/* src/voice_mix.sv */
`timescale 1ns/1ps

module voice_mix
    import synth_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [6:0] saw,
    input  param_t     env_level,
    input  param_t     amplitude,
    output logic [6:0] wave_out
);

    // 7 + 6 + 6 bits, full scale 127 * 63 * 63
    logic [18:0] product;

    assign product = saw * env_level * amplitude;

    // drop 12 bits, back to 7-bit sample range
    // zero env or zero amplitude gives a zero product, so silence is exact
    always_ff @(posedge clk) begin
        if (!reset)
            wave_out <= '0;
        else
            wave_out <= product[18:12];
    end

endmodule

/* testbench/synth_checker.sv */
`timescale 1ns/1ps

module synth_checker
    import synth_pkg::*;
#(
    parameter int ENV_DIV = 16
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       key_valid,
    input  logic [7:0] key_code,        // raw bits, decoded here by hand
    input  logic [6:0] wave_out,
    input  param_t     env_level,
    input  logic       gate,
    input  logic [2:0] octave,
    input  param_t     amplitude,
    input  logic [1:0] stage_sel,
    input  param_t     stage_value,
    input  logic       check_req,       // end of one table row
    input  logic [2:0] exp_octave,
    input  param_t     exp_amplitude,
    input  logic [1:0] exp_stage,
    input  param_t     exp_stage_value,
    input  logic       exp_gate,
    input  logic [1:0] exp_env,         // 0 any, 1 silent, 2 full
    input  logic       exp_wave,        // wave_out must go nonzero in the row
    output int         error_count
);

    // model of the slider registers
    logic [3:0] m_note;
    logic       m_gate;
    logic [2:0] m_octave;
    param_t     m_amp;
    logic [1:0] m_stage;
    param_t     m_val [4];   // attack, decay, sustain, release
    int         high_cnt;    // samples with gate high in a row
    int         low_cnt;
    logic       prev_silent; // mix inputs held a zero last edge
    logic       wave_seen;
    logic       full_env;    // attack, sustain and release all at max

    task automatic compare_value(input string what, input int got, input int want);
        if (got != want) begin
            error_count++;
            $display("Mismatch at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    // one step, clamped to 0..limit
    function automatic int saturate_step(input int value, input logic up, input int limit);
        if (up)
            return (value < limit) ? value + 1 : limit;
        return (value > 0) ? value - 1 : 0;
    endfunction

    initial begin
        error_count = 0;
        for (int i = 0; i < 12; i++) begin
            if (NOTE_INC[i] == 0) begin
                error_count++;
                $display("Mismatch at %0t: NOTE_INC[%0d] is 0", $time, i);
            end
        end
    end

    always @(posedge clk) begin
        if (!reset) begin
            m_note      = '0;
            m_gate      = 1'b0;
            m_octave    = DEF_OCTAVE;
            m_amp       = DEF_AMPLITUDE;
            m_stage     = 2'd0;
            m_val[0]    = DEF_ATTACK;
            m_val[1]    = DEF_DECAY;
            m_val[2]    = DEF_SUSTAIN;
            m_val[3]    = DEF_RELEASE;
            high_cnt    = 0;
            low_cnt     = 0;
            prev_silent = 1'b1;  // wave_out clears in reset
            wave_seen   = 1'b0;
        end else begin
            compare_value("gate", gate, m_gate);
            compare_value("octave", octave, m_octave);
            compare_value("amplitude", amplitude, m_amp);
            compare_value("stage_sel", stage_sel, m_stage);
            compare_value("stage_value", stage_value, m_val[m_stage]);
            if (prev_silent)
                compare_value("wave_out after silent mix input", wave_out, 0);

            // envelope latency, one tick period plus pipeline
            if (gate) begin
                high_cnt++;
                low_cnt = 0;
            end else begin
                low_cnt++;
                high_cnt = 0;
            end
            full_env = (m_val[0] == PARAM_MAX) && (m_val[2] == PARAM_MAX)
                       && (m_val[3] == PARAM_MAX);
            if (full_env && high_cnt > ENV_DIV + 2)
                compare_value("env_level while held", env_level, PARAM_MAX);
            if (m_val[3] == PARAM_MAX && low_cnt > ENV_DIV + 2)
                compare_value("env_level after release", env_level, 0);

            wave_seen   = wave_seen || (wave_out != '0);
            prev_silent = (env_level == '0) || (amplitude == '0);

            if (check_req) begin  // row end, table values
                compare_value("row octave", octave, exp_octave);
                compare_value("row amplitude", amplitude, exp_amplitude);
                compare_value("row stage_sel", stage_sel, exp_stage);
                compare_value("row stage_value", stage_value, exp_stage_value);
                compare_value("row gate", gate, exp_gate);
                if (exp_env == 2'd1)
                    compare_value("row env_level", env_level, 0);
                else if (exp_env == 2'd2)
                    compare_value("row env_level", env_level, PARAM_MAX);
                if (exp_wave && !wave_seen) begin
                    error_count++;
                    $display("Mismatch at %0t: wave_out stayed 0 for the whole row", $time);
                end
                wave_seen = 1'b0;
            end

            // key word taken on the same edge as the DUT
            if (key_valid) begin
                if (!key_code[7]) begin
                    if (key_code[6] && key_code[3:0] < 4'd12) begin
                        m_note = key_code[3:0];
                        m_gate = 1'b1;
                    end else if (!key_code[6] && key_code[3:0] == m_note) begin
                        m_gate = 1'b0;
                    end
                end else begin
                    case (key_code[6:5])
                        2'd0: m_octave = 3'(saturate_step(m_octave, key_code[0], OCTAVE_MAX));
                        2'd1: m_amp = 6'(saturate_step(m_amp, key_code[0], PARAM_MAX));
                        2'd2: m_stage = key_code[4:3];
                        default: m_val[m_stage] =
                            6'(saturate_step(m_val[m_stage], key_code[0], PARAM_MAX));
                    endcase
                end
            end
        end
    end

endmodule

/* testbench/synth_tb.sv */
`timescale 1ns/1ps

module synth_tb
    import synth_pkg::*;
();

    localparam int ENV_DIV  = 16;
    localparam int PHASE_W  = 20;
    localparam int MAX_ROWS = 32;
    localparam int ENV_IDLE = ENV_DIV + 4;  // room for one full tick period
    localparam logic [1:0] ENV_ANY  = 2'd0;
    localparam logic [1:0] ENV_ZERO = 2'd1;
    localparam logic [1:0] ENV_FULL = 2'd2;

    logic       clk;
    logic       reset;
    logic       key_valid;
    key_event_t key_code;
    logic [6:0] wave_out;
    param_t     env_level;
    logic       gate;
    logic [2:0] octave;
    param_t     amplitude;
    stage_e     stage_sel;
    param_t     stage_value;

    // row end strobe and expected values for the checker
    logic       check_req;
    logic [2:0] exp_octave;
    param_t     exp_amplitude;
    logic [1:0] exp_stage;
    param_t     exp_stage_value;
    logic       exp_gate;
    logic [1:0] exp_env;
    logic       exp_wave;
    int         error_count;

    // stimulus table
    logic [7:0] row_code  [MAX_ROWS];
    int         row_reps  [MAX_ROWS];  // back to back strobes
    int         row_idle  [MAX_ROWS];  // quiet cycles before the check
    logic [2:0] row_oct   [MAX_ROWS];
    param_t     row_amp   [MAX_ROWS];
    logic [1:0] row_stage [MAX_ROWS];
    param_t     row_value [MAX_ROWS];
    logic       row_gate  [MAX_ROWS];
    logic [1:0] row_env   [MAX_ROWS];
    logic       row_wave  [MAX_ROWS];
    int         num_rows     = 0;
    int         total_cycles = 0;

    synth_top #(
        .ENV_DIV (ENV_DIV),
        .PHASE_W (PHASE_W)
    ) u_dut (
        .clk         (clk),
        .reset       (reset),
        .key_valid   (key_valid),
        .key_code    (key_code),
        .wave_out    (wave_out),
        .env_level   (env_level),
        .gate        (gate),
        .octave      (octave),
        .amplitude   (amplitude),
        .stage_sel   (stage_sel),
        .stage_value (stage_value)
    );

    synth_checker #(
        .ENV_DIV (ENV_DIV)
    ) u_check (
        .clk (clk), .reset (reset), .key_valid (key_valid), .key_code (key_code),
        .wave_out (wave_out), .env_level (env_level), .gate (gate), .octave (octave),
        .amplitude (amplitude), .stage_sel (stage_sel), .stage_value (stage_value),
        .check_req (check_req), .exp_octave (exp_octave), .exp_amplitude (exp_amplitude),
        .exp_stage (exp_stage), .exp_stage_value (exp_stage_value), .exp_gate (exp_gate),
        .exp_env (exp_env), .exp_wave (exp_wave), .error_count (error_count)
    );

    // key word layouts
    function automatic logic [7:0] note_word(input logic press, input logic [3:0] idx);
        return {1'b0, press, 2'b00, idx};
    endfunction

    function automatic logic [7:0] adjust_word(input logic [1:0] target, input logic [1:0] stage,
                                               input logic up);
        return {1'b1, target, stage, 2'b00, up};
    endfunction

    task automatic add_row(input logic [7:0] code, input int reps, input int idle,
                           input int oct, input int amp, input int stage, input int value,
                           input logic g, input logic [1:0] env, input logic wave);
        row_code[num_rows]  = code;
        row_reps[num_rows]  = reps;
        row_idle[num_rows]  = idle;
        row_oct[num_rows]   = 3'(oct);
        row_amp[num_rows]   = 6'(amp);
        row_stage[num_rows] = 2'(stage);
        row_value[num_rows] = 6'(value);
        row_gate[num_rows]  = g;
        row_env[num_rows]   = env;
        row_wave[num_rows]  = wave;
        total_cycles += reps + idle + 1;
        num_rows++;
    endtask

    task automatic load_table();
        add_row(8'h00, 0, 2, 4, 63, 0, 63, 0, ENV_ZERO, 0);               // reset values
        add_row(adjust_word(0, 0, 1), 8, 2, 7, 63, 0, 63, 0, ENV_ZERO, 0); // octave caps at 7
        add_row(adjust_word(0, 0, 0), 3, 2, 4, 63, 0, 63, 0, ENV_ZERO, 0);
        add_row(adjust_word(0, 0, 0), 6, 2, 0, 63, 0, 63, 0, ENV_ZERO, 0); // floor at 0
        add_row(adjust_word(0, 0, 1), 4, 2, 4, 63, 0, 63, 0, ENV_ZERO, 0);
        add_row(adjust_word(1, 0, 1), 1, 2, 4, 63, 0, 63, 0, ENV_ZERO, 0); // amp already max
        add_row(adjust_word(1, 0, 0), 5, 2, 4, 58, 0, 63, 0, ENV_ZERO, 0);
        add_row(adjust_word(1, 0, 1), 9, 2, 4, 63, 0, 63, 0, ENV_ZERO, 0);
        add_row(adjust_word(2, 1, 0), 1, 2, 4, 63, 1, 0, 0, ENV_ZERO, 0);  // select decay
        add_row(adjust_word(3, 0, 1), 10, 2, 4, 63, 1, 10, 0, ENV_ZERO, 0);
        add_row(adjust_word(3, 0, 0), 4, 2, 4, 63, 1, 6, 0, ENV_ZERO, 0);
        add_row(adjust_word(2, 2, 1), 1, 2, 4, 63, 2, 63, 0, ENV_ZERO, 0); // sustain untouched
        add_row(adjust_word(3, 0, 1), 2, 2, 4, 63, 2, 63, 0, ENV_ZERO, 0);
        add_row(adjust_word(2, 3, 0), 1, 2, 4, 63, 3, 63, 0, ENV_ZERO, 0);
        add_row(adjust_word(2, 0, 0), 1, 2, 4, 63, 0, 63, 0, ENV_ZERO, 0);
        add_row(note_word(1, 9), 1, ENV_IDLE, 4, 63, 0, 63, 1, ENV_FULL, 0);
        add_row(note_word(1, 13), 1, 4, 4, 63, 0, 63, 1, ENV_FULL, 0);     // bad index
        add_row(note_word(0, 3), 1, 4, 4, 63, 0, 63, 1, ENV_FULL, 0);      // other note
        add_row(note_word(0, 9), 1, ENV_IDLE, 4, 63, 0, 63, 0, ENV_ZERO, 0);
        add_row(adjust_word(0, 0, 1), 3, 2, 7, 63, 0, 63, 0, ENV_ZERO, 0);
        add_row(note_word(1, 11), 1, ENV_IDLE, 7, 63, 0, 63, 1, ENV_FULL, 0);
        add_row(adjust_word(1, 0, 0), 70, 40, 7, 0, 0, 63, 1, ENV_FULL, 0); // muted
        add_row(adjust_word(1, 0, 1), 63, 64, 7, 63, 0, 63, 1, ENV_FULL, 1);
        add_row(note_word(0, 11), 1, ENV_IDLE, 7, 63, 0, 63, 0, ENV_ZERO, 0);
        total_cycles += 5 + 4;  // reset and tail
    endtask

    // strobes, idle, then hand the row to the checker
    task automatic apply_row(input int r);
        for (int n = 0; n < row_reps[r]; n++) begin
            key_valid <= 1'b1;
            key_code  <= row_code[r];
            @(posedge clk);
        end
        key_valid <= 1'b0;
        repeat (row_idle[r]) @(posedge clk);
        exp_octave      <= row_oct[r];
        exp_amplitude   <= row_amp[r];
        exp_stage       <= row_stage[r];
        exp_stage_value <= row_value[r];
        exp_gate        <= row_gate[r];
        exp_env         <= row_env[r];
        exp_wave        <= row_wave[r];
        check_req       <= 1'b1;
        @(posedge clk);
        check_req <= 1'b0;
    endtask

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns
    end

    initial begin : watchdog
        wait (total_cycles > 0);
        #(longint'(total_cycles) * 2 * 8);
        $display("Timeout: the stimulus table did not finish within %0d cycles, %0d errors",
                 total_cycles * 2, error_count);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        reset           = 1'b0;
        key_valid       = 1'b0;
        key_code        = '0;
        check_req       = 1'b0;
        exp_octave      = '0;
        exp_amplitude   = '0;
        exp_stage       = '0;
        exp_stage_value = '0;
        exp_gate        = 1'b0;
        exp_env         = ENV_ANY;
        exp_wave        = 1'b0;
        load_table();
        repeat (5) @(posedge clk);
        reset <= 1'b1;
        for (int r = 0; r < num_rows; r++)
            apply_row(r);
        repeat (3) @(posedge clk);
        $display("Run complete with %0d errors", error_count);
        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
